// File: verilog/exu_pkg.sv
`default_nettype none

package exu_pkg;

    // ------------------------------
    // opcodes and selects
    // ------------------------------

    // low three bits follow funct3 and bit 3 picks sub or sra
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_e;

    // operand pair feeding the alu
    typedef enum logic [1:0] {
        opd_imm_zero = 2'b00,
        opd_pc_imm   = 2'b01,
        opd_rs1_rs2  = 2'b10,
        opd_rs1_imm  = 2'b11
    } opd_sel_e;

    typedef enum logic [2:0] {
        br_seq       = 3'd0,
        br_zero      = 3'd1,
        br_nonzero   = 3'd2,
        br_lsb_set   = 3'd3,
        br_lsb_clear = 3'd4,
        br_jump      = 3'd5,
        br_jump_reg  = 3'd6
    } br_kind_e;

    typedef enum logic [1:0] {
        mem_none  = 2'b00,
        mem_load  = 2'b01,
        mem_store = 2'b10
    } mem_op_e;

    // 00 is unused
    typedef enum logic [1:0] {
        size_byte = 2'b01,
        size_half = 2'b10,
        size_word = 2'b11
    } mem_size_e;

    // ------------------------------
    // stage payloads
    // ------------------------------

    typedef struct packed {
        alu_op_e     alu_op;
        opd_sel_e    opd_sel;
        br_kind_e    br_kind;
        mem_op_e     mem_op;
        mem_size_e   mem_size;
        logic        mem_signed;
        logic [31:0] pc;
        logic [31:0] rs1_data;
        logic [31:0] rs2_data;
        logic [31:0] imm;
    } exu_uop_t;

    typedef struct packed {
        exu_uop_t    uop;
        logic [31:0] opa;
        logic [31:0] opb;
    } exu_opnd_t;

    typedef struct packed {
        logic [31:0] alu_res;
        logic [31:0] next_pc;
        logic [31:0] link;
        mem_op_e     mem_op;
        mem_size_e   mem_size;
        logic        mem_signed;
        logic [31:0] rs2_data;
        logic        is_link;
    } exu_exec_t;

    typedef struct packed {
        logic [31:0] rd_data;
        logic [31:0] next_pc;
    } exu_result_t;

endpackage

`default_nettype wire

// File: verilog/exu_next_pc.sv
`timescale 1ns/10ps
`default_nettype none

module exu_next_pc import exu_pkg::*; (
    input  br_kind_e    br_kind,
    input  logic [31:0] alu_res,
    input  logic [31:0] pc,
    input  logic [31:0] rs1_data,
    input  logic [31:0] imm,
    output logic [31:0] next_pc
);

    logic        taken;
    logic        is_jalr;
    logic [31:0] ina;
    logic [31:0] inb;
    logic [31:0] sum;

    assign is_jalr = (br_kind == br_jump_reg);

    // branch decision from the alu result
    always_comb begin
        case (br_kind)
            br_zero:      taken = (alu_res == '0);
            br_nonzero:   taken = |alu_res;
            br_lsb_set:   taken = alu_res[0];
            br_lsb_clear: taken = ~alu_res[0];
            br_jump:      taken = 1'b1;
            br_jump_reg:  taken = 1'b1;
            default:      taken = 1'b0;
        endcase
    end

    // one shared adder for all three targets
    assign ina = is_jalr ? rs1_data : pc;
    assign inb = taken ? imm : 32'd4;
    assign sum = ina + inb;

    // jalr clears bit 0
    assign next_pc = {sum[31:1], sum[0] & ~is_jalr};

endmodule

`default_nettype wire

// File: verilog/exu_operand_sel.sv
`timescale 1ns/10ps
`default_nettype none

module exu_operand_sel import exu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  exu_uop_t  in_uop,
    output logic      opnd_valid,
    output exu_opnd_t opnd
);

    logic [31:0] opa;
    logic [31:0] opb;

    // operand pair mux
    always_comb begin
        case (in_uop.opd_sel)
            opd_imm_zero: begin
                // lui
                opa = in_uop.imm;
                opb = '0;
            end
            opd_pc_imm: begin
                opa = in_uop.pc;
                opb = in_uop.imm;
            end
            opd_rs1_rs2: begin
                opa = in_uop.rs1_data;
                opb = in_uop.rs2_data;
            end
            default: begin
                opa = in_uop.rs1_data;
                opb = in_uop.imm;
            end
        endcase
    end

    // strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            opnd_valid <= 1'b0;
        end else begin
            opnd_valid <= in_valid;
        end
    end

    // payload, only loaded on a strobe
    always_ff @(posedge clk) begin
        if (in_valid) begin
            opnd.uop <= in_uop;
            opnd.opa <= opa;
            opnd.opb <= opb;
        end
    end

endmodule

`default_nettype wire

// File: verilog/exu_alu.sv
`timescale 1ns/10ps
`default_nettype none

module exu_alu import exu_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      opnd_valid,
    input  exu_opnd_t opnd,
    output logic      exec_valid,
    output exu_exec_t exec
);

    logic [31:0] alu_res;
    logic [31:0] next_pc;
    logic [4:0]  shamt;

    // only the low five bits shift
    assign shamt = opnd.opb[4:0];

    // ------------------------------
    // alu
    // ------------------------------
    always_comb begin
        case (opnd.uop.alu_op)
            alu_add:  alu_res = opnd.opa + opnd.opb;
            alu_sub:  alu_res = opnd.opa - opnd.opb;
            alu_sll:  alu_res = opnd.opa << shamt;
            alu_slt:  alu_res = {31'b0, $signed(opnd.opa) < $signed(opnd.opb)};
            alu_sltu: alu_res = {31'b0, opnd.opa < opnd.opb};
            alu_xor:  alu_res = opnd.opa ^ opnd.opb;
            alu_srl:  alu_res = opnd.opa >> shamt;
            alu_sra:  alu_res = $unsigned($signed(opnd.opa) >>> shamt);
            alu_or:   alu_res = opnd.opa | opnd.opb;
            alu_and:  alu_res = opnd.opa & opnd.opb;
            default:  alu_res = '0;
        endcase
    end

    // next pc sits beside the alu, same cycle
    exu_next_pc u_next_pc (
        .br_kind  (opnd.uop.br_kind),
        .alu_res  (alu_res),
        .pc       (opnd.uop.pc),
        .rs1_data (opnd.uop.rs1_data),
        .imm      (opnd.uop.imm),
        .next_pc  (next_pc)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            exec_valid <= 1'b0;
        end else begin
            exec_valid <= opnd_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (opnd_valid) begin
            exec.alu_res    <= alu_res;
            exec.next_pc    <= next_pc;
            exec.link       <= opnd.uop.pc + 32'd4;
            // memory side, passed through
            exec.mem_op     <= opnd.uop.mem_op;
            exec.mem_size   <= opnd.uop.mem_size;
            exec.mem_signed <= opnd.uop.mem_signed;
            exec.rs2_data   <= opnd.uop.rs2_data;
            exec.is_link    <= (opnd.uop.br_kind == br_jump) ||
                               (opnd.uop.br_kind == br_jump_reg);
        end
    end

endmodule

`default_nettype wire

// File: verilog/exu_lsu.sv
`timescale 1ns/10ps
`default_nettype none

module exu_lsu import exu_pkg::*; #(
    parameter int mem_words = 256
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        exec_valid,
    input  exu_exec_t   exec,
    output logic        out_valid,
    output exu_result_t out_result
);

    localparam int addr_w = $clog2(mem_words);

    logic [31:0]       mem [mem_words];
    logic [addr_w-1:0] addr;
    logic [4:0]        wr_shamt;
    logic [3:0]        wmask;
    logic [31:0]       wdata;
    logic              wr_en;
    logic              rd_en;
    exu_exec_t         exec_q;
    logic [31:0]       rd_word;
    logic [31:0]       rd_lane;
    logic [31:0]       ld_data;

    // bit offset of the addressed lane, half ignores bit 0
    function automatic logic [4:0] lane_shamt(mem_size_e size, logic [1:0] low);
        case (size)
            size_byte: return {low, 3'b000};
            size_half: return {low[1], 4'b0000};
            default:   return 5'd0;
        endcase
    endfunction

    // word index, wraps at mem_words
    assign addr  = exec.alu_res[addr_w+1:2];
    assign wr_en = exec_valid && (exec.mem_op == mem_store);
    assign rd_en = exec_valid && (exec.mem_op == mem_load);

    // ------------------------------
    // store lanes
    // ------------------------------
    always_comb begin
        wr_shamt = lane_shamt(exec.mem_size, exec.alu_res[1:0]);
        wdata    = exec.rs2_data << wr_shamt;
        case (exec.mem_size)
            size_byte: wmask = 4'b0001 << exec.alu_res[1:0];
            size_half: wmask = exec.alu_res[1] ? 4'b1100 : 4'b0011;
            default:   wmask = 4'b1111;
        endcase
    end

    initial begin
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = '0;
        end
    end

    // read before write on the same edge
    always @(posedge clk) begin
        if (rd_en) begin
            rd_word <= mem[addr];
        end
        if (wr_en) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask[b]) begin
                    mem[addr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= exec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_valid) begin
            exec_q <= exec;
        end
    end

    // ------------------------------
    // load format and writeback
    // ------------------------------
    always_comb begin
        rd_lane = rd_word >> lane_shamt(exec_q.mem_size, exec_q.alu_res[1:0]);
        case (exec_q.mem_size)
            size_byte: ld_data = {{24{rd_lane[7] & exec_q.mem_signed}}, rd_lane[7:0]};
            size_half: ld_data = {{16{rd_lane[15] & exec_q.mem_signed}}, rd_lane[15:0]};
            default:   ld_data = rd_lane;
        endcase
        if (exec_q.mem_op == mem_load) begin
            out_result.rd_data = ld_data;
        end else if (exec_q.is_link) begin
            out_result.rd_data = exec_q.link;
        end else if (exec_q.mem_op == mem_store) begin
            out_result.rd_data = '0;
        end else begin
            out_result.rd_data = exec_q.alu_res;
        end
        out_result.next_pc = exec_q.next_pc;
    end

endmodule

`default_nettype wire

// File: verilog/exu_top.sv
`timescale 1ns/10ps
`default_nettype none

module exu_top import exu_pkg::*; #(
    parameter int mem_words = 256
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        in_valid,
    input  exu_uop_t    in_uop,
    output logic        out_valid,
    output exu_result_t out_result
);

    logic      opnd_valid;
    exu_opnd_t opnd;
    logic      exec_valid;
    exu_exec_t exec;

    // ------------------------------
    // stage 1 operand select
    // ------------------------------
    exu_operand_sel u_operand_sel (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_uop     (in_uop),
        .opnd_valid (opnd_valid),
        .opnd       (opnd)
    );

    // stage 2, alu and next pc
    exu_alu u_alu (
        .clk        (clk),
        .rst        (rst),
        .opnd_valid (opnd_valid),
        .opnd       (opnd),
        .exec_valid (exec_valid),
        .exec       (exec)
    );

    // stage 3, memory and writeback
    exu_lsu #(
        .mem_words (mem_words)
    ) u_lsu (
        .clk        (clk),
        .rst        (rst),
        .exec_valid (exec_valid),
        .exec       (exec),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

endmodule

`default_nettype wire

// File: dv/exu_properties.sv
`timescale 1ns/10ps
`default_nettype none

module exu_properties import exu_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        in_valid,
    input logic        out_valid,
    input exu_result_t out_result
);

    // failure count, read by the testbench summary
    int n_fail = 0;

    // quiet output while reset is held and one cycle after
    a_reset_quiet: assert property (@(posedge clk) rst |=> !out_valid)
        else begin
            n_fail++;
            $error("out_valid high during or right after reset");
        end

    // fixed three cycle latency, every result has a strobe behind it
    a_latency: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> $past(in_valid, 3))
        else begin
            n_fail++;
            $error("out_valid without in_valid three cycles earlier");
        end

    a_known: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> !$isunknown(out_result))
        else begin
            n_fail++;
            $error("out_result has unknown bits while out_valid is high");
        end

endmodule

bind exu_top exu_properties props_i (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .out_valid  (out_valid),
    .out_result (out_result)
);

`default_nettype wire

// File: dv/exu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module exu_tb import exu_pkg::*;;

    localparam int mem_words  = 256;
    localparam int clk_period = 40;
    localparam int rst_cycles = 10;
    // 160 alu, 16 upper imm, 56 branch, 21 memory, 200 random
    localparam int num_uops   = 453;

    logic        clk;
    logic        rst;
    logic        in_valid;
    exu_uop_t    in_uop;
    logic        out_valid;
    exu_result_t out_result;

    logic [31:0] lcg_state;
    logic [31:0] shadow [mem_words];
    exu_result_t exp_q[$];
    int          cyc_q[$];
    int          cyc = 0;
    int          n_sent = 0;
    int          n_recv = 0;
    int          n_value_err = 0;
    int          n_proto_err = 0;

    alu_op_e   alu_ops[10] = '{alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
                               alu_xor, alu_srl, alu_sra, alu_or, alu_and};
    opd_sel_e  sels[4]  = '{opd_imm_zero, opd_pc_imm, opd_rs1_rs2, opd_rs1_imm};
    br_kind_e  kinds[7] = '{br_seq, br_zero, br_nonzero, br_lsb_set, br_lsb_clear,
                            br_jump, br_jump_reg};
    mem_op_e   mops[3]  = '{mem_none, mem_load, mem_store};
    mem_size_e sizes[3] = '{size_byte, size_half, size_word};

    exu_top #(
        .mem_words (mem_words)
    ) dut_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_uop     (in_uop),
        .out_valid  (out_valid),
        .out_result (out_result)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ------------------------------
    // random source and helpers
    // ------------------------------
    function automatic logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // the low lcg bits cycle quickly so take the upper ones
    function automatic int pick(int n);
        return (rand32() >> 16) % n;
    endfunction

    function automatic exu_uop_t plain_uop();
        exu_uop_t u;
        u = '0;
        u.alu_op   = alu_add;
        u.opd_sel  = opd_rs1_rs2;
        u.br_kind  = br_seq;
        u.mem_op   = mem_none;
        u.mem_size = size_word;
        u.pc       = rand32() & 32'hffff_fffc;
        u.rs1_data = rand32();
        u.rs2_data = rand32();
        u.imm      = rand32();
        return u;
    endfunction

    // ------------------------------
    // reference model
    // ------------------------------
    function automatic logic [31:0] alu_model(alu_op_e op, logic [31:0] a, logic [31:0] b);
        logic [4:0]  sh;
        logic [31:0] fill;
        sh = b[4:0];
        // sign bits shifted in from the top
        fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
        case (op)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_sll:  return a << sh;
            alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            alu_xor:  return a ^ b;
            alu_srl:  return a >> sh;
            alu_sra:  return (a >> sh) | fill;
            alu_or:   return a | b;
            default:  return a & b;
        endcase
    endfunction

    function automatic logic [31:0] alu_out(exu_uop_t u);
        logic [31:0] a;
        logic [31:0] b;
        a = (u.opd_sel == opd_imm_zero) ? u.imm : (u.opd_sel == opd_pc_imm) ? u.pc : u.rs1_data;
        b = (u.opd_sel == opd_imm_zero) ? 32'h0 :
            (u.opd_sel == opd_rs1_rs2) ? u.rs2_data : u.imm;
        return alu_model(u.alu_op, a, b);
    endfunction

    function automatic int mem_index(logic [31:0] addr);
        return (addr >> 2) % mem_words;
    endfunction

    function automatic exu_result_t ref_result(exu_uop_t u);
        logic [31:0] res;
        logic [31:0] word;
        logic [31:0] lane;
        logic        taken;
        exu_result_t r;
        res = alu_out(u);
        case (u.br_kind)
            br_zero:      taken = (res == 32'h0);
            br_nonzero:   taken = (res != 32'h0);
            br_lsb_set:   taken = res[0];
            br_lsb_clear: taken = !res[0];
            br_jump:      taken = 1'b1;
            default:      taken = 1'b0;
        endcase
        if (u.br_kind == br_jump_reg) begin
            r.next_pc = (u.rs1_data + u.imm) & 32'hffff_fffe;
        end else begin
            r.next_pc = taken ? u.pc + u.imm : u.pc + 32'd4;
        end
        word = shadow[mem_index(res)];
        case (u.mem_size)
            size_byte: begin
                lane = (word >> (8 * res[1:0])) & 32'hff;
                if (u.mem_signed && lane[7])
                    lane = lane | 32'hffff_ff00;
            end
            size_half: begin
                lane = (word >> (16 * res[1])) & 32'hffff;
                if (u.mem_signed && lane[15])
                    lane = lane | 32'hffff_0000;
            end
            default: lane = word;
        endcase
        // writeback priority is load then link then store then alu
        if (u.mem_op == mem_load)
            r.rd_data = lane;
        else if (u.br_kind == br_jump || u.br_kind == br_jump_reg)
            r.rd_data = u.pc + 32'd4;
        else if (u.mem_op == mem_store)
            r.rd_data = 32'h0;
        else
            r.rd_data = res;
        return r;
    endfunction

    task automatic store_shadow(exu_uop_t u);
        logic [31:0] addr;
        int          idx;
        addr = alu_out(u);
        idx  = mem_index(addr);
        case (u.mem_size)
            size_byte: shadow[idx][8 * addr[1:0] +: 8] = u.rs2_data[7:0];
            size_half: shadow[idx][16 * addr[1] +: 16] = u.rs2_data[15:0];
            default:   shadow[idx] = u.rs2_data;
        endcase
    endtask

    // one strobe with its expected result queued in program order
    task automatic send(exu_uop_t u);
        @(posedge clk);
        #2;
        in_valid = 1'b1;
        in_uop   = u;
        exp_q.push_back(ref_result(u));
        cyc_q.push_back(cyc);
        if (u.mem_op == mem_store) begin
            store_shadow(u);
        end
        n_sent++;
    endtask

    // ------------------------------
    // scoreboard
    // ------------------------------
    always @(negedge clk) begin
        exu_result_t exp_res;
        int          issue_cyc;
        if (out_valid === 1'b1) begin
            n_recv++;
            if (exp_q.size() == 0) begin
                n_proto_err++;
                $display("result arrived with no micro-op outstanding at %0t", $time);
            end else begin
                exp_res   = exp_q.pop_front();
                issue_cyc = cyc_q.pop_front();
                if (cyc != issue_cyc + 3) begin
                    n_proto_err++;
                    $display("result %0d came %0d cycles after its strobe, not 3",
                             n_recv, cyc - issue_cyc);
                end
                if (out_result.rd_data !== exp_res.rd_data) begin
                    n_value_err++;
                    $display("[ERROR] rd_data got 0x%08h expected 0x%08h",
                             out_result.rd_data, exp_res.rd_data);
                end
                if (out_result.next_pc !== exp_res.next_pc) begin
                    n_value_err++;
                    $display("[ERROR] next_pc got 0x%08h expected 0x%08h",
                             out_result.next_pc, exp_res.next_pc);
                end
            end
        end
    end

    // watchdog over the run length plus margin
    initial begin
        #((num_uops + rst_cycles + 20) * clk_period);
        $display("timeout: results still missing after %0d of %0d micro-ops", n_recv, n_sent);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // ------------------------------
    // stimulus
    // ------------------------------
    initial begin
        exu_uop_t u;
        int       total;
        in_valid  = 1'b0;
        in_uop    = '0;
        rst       = 1'b1;
        lcg_state = 32'hcbbd;
        for (int i = 0; i < mem_words; i++) begin
            shadow[i] = 32'h0;
        end
        repeat (rst_cycles) @(posedge clk);
        #2;
        rst = 1'b0;

        // every alu op with register and immediate operands
        for (int i = 0; i < 10; i++) begin
            for (int j = 0; j < 16; j++) begin
                u = plain_uop();
                u.alu_op  = alu_ops[i];
                u.opd_sel = (j < 8) ? opd_rs1_rs2 : opd_rs1_imm;
                // equal and sign-flipped pairs for the compares
                if (j % 4 == 1)
                    u.rs2_data = u.rs1_data;
                if (j % 4 == 2)
                    u.rs2_data = u.rs1_data ^ 32'h8000_0000;
                if (j >= 8)
                    u.imm = u.rs2_data;
                send(u);
            end
        end

        // lui then auipc
        for (int j = 0; j < 16; j++) begin
            u = plain_uop();
            u.imm     = u.imm & 32'hffff_f000;
            u.opd_sel = (j < 8) ? opd_imm_zero : opd_pc_imm;
            send(u);
        end

        // branch kinds and jumps
        for (int k = 0; k < 7; k++) begin
            for (int j = 0; j < 8; j++) begin
                u = plain_uop();
                u.br_kind = kinds[k];
                if (j % 2 == 1)
                    u.rs2_data = u.rs1_data;
                if (kinds[k] == br_jump)
                    u.opd_sel = opd_pc_imm;
                else if (kinds[k] == br_jump_reg)
                    u.opd_sel = opd_rs1_imm;
                else if (kinds[k] == br_lsb_set || kinds[k] == br_lsb_clear)
                    u.alu_op = (j < 4) ? alu_slt : alu_sltu;
                else
                    u.alu_op = alu_sub;
                send(u);
            end
        end

        // store then both loads at every lane of every size
        for (int s = 0; s < 3; s++) begin
            for (int off = 0; off < 4; off += (1 << s)) begin
                u = plain_uop();
                u.opd_sel  = opd_rs1_imm;
                u.rs1_data = 32'h100 + 16 * s;
                u.imm      = off;
                u.mem_size = sizes[s];
                u.mem_op   = mem_store;
                send(u);
                u.mem_op     = mem_load;
                u.mem_signed = 1'b0;
                send(u);
                u.mem_signed = 1'b1;
                send(u);
            end
        end

        // full-rate random mix
        for (int j = 0; j < 200; j++) begin
            u = plain_uop();
            u.alu_op     = alu_ops[pick(10)];
            u.opd_sel    = sels[pick(4)];
            u.br_kind    = kinds[pick(7)];
            u.mem_op     = mops[pick(3)];
            u.mem_size   = sizes[pick(3)];
            u.mem_signed = (pick(2) != 0);
            // small address window so loads hit earlier stores
            if (u.mem_op != mem_none) begin
                u.alu_op   = alu_add;
                u.opd_sel  = opd_rs1_imm;
                u.rs1_data = 32'h100 + pick(64);
                u.imm      = pick(16);
            end
            send(u);
        end

        @(posedge clk);
        #2;
        in_valid = 1'b0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (4) @(posedge clk);

        if (n_recv != n_sent) begin
            n_proto_err++;
            $display("received %0d results for %0d micro-ops", n_recv, n_sent);
        end
        total = n_value_err + n_proto_err + dut_i.props_i.n_fail;
        $display("summary: %0d value errors, %0d protocol errors, %0d assertion failures",
                 n_value_err, n_proto_err, dut_i.props_i.n_fail);
        if (total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
verilog/exu_pkg.sv
verilog/exu_next_pc.sv
verilog/exu_operand_sel.sv
verilog/exu_alu.sv
verilog/exu_lsu.sv
verilog/exu_top.sv
dv/exu_properties.sv
dv/exu_tb.sv

// File: Bender.yml
package:
  name: exu

sources:
  - files:
      - verilog/exu_pkg.sv
      - verilog/exu_next_pc.sv
      - verilog/exu_operand_sel.sv
      - verilog/exu_alu.sv
      - verilog/exu_lsu.sv
      - verilog/exu_top.sv
  - target: simulation
    files:
      - dv/exu_properties.sv
      - dv/exu_tb.sv
